// File: flist.f
source/nnPkg.sv
source/macBus.sv
source/layerControl.sv
source/inputCounter.sv
source/weightRom.sv
source/neuronMac.sv
source/denseLayer.sv
testbench/clockGen.sv
testbench/layerTb.sv

// File: run.sh
#!/bin/sh
# build and run the dense layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module layerTb -f flist.f -Mdir "$BUILD_DIR" -o layerTb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/layerTb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -q "^TB PASSED$" "$LOG_FILE"
if [ $? -ne 0 ]; then
	echo "pass message not found in $LOG_FILE"
	exit 1
fi

echo "simulation result: pass"
exit 0

// File: source/denseLayer.sv
`timescale 1ns/100ps
`default_nettype none

module denseLayer
#(
	parameter int NUM_INPUTS = 30,
	parameter int NUM_NEURONS = 4
)
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire nnPkg::dataWord sample,
	input wire sampleValid,
	output nnPkg::actWord activations [NUM_NEURONS],
	output logic busy,
	output logic done
);

	localparam int INDEX_WIDTH = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

	logic countClear;
	logic countEnable;
	logic lastSample;
	logic [INDEX_WIDTH-1:0] index;

	macBus #(
		.NUM_NEURONS(NUM_NEURONS)
	) bus ();

	layerControl layerControl_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.sampleValid(sampleValid),
		.lastSample(lastSample),
		.countClear(countClear),
		.countEnable(countEnable),
		.busy(busy),
		.done(done),
		.bus(bus.control)
	);

	inputCounter #(
		.NUM_INPUTS(NUM_INPUTS)
	) inputCounter_i
	(
		.clk(clk),
		.reset(reset),
		.countClear(countClear),
		.countEnable(countEnable),
		.index(index),
		.lastSample(lastSample)
	);

	weightRom #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) weightRom_i
	(
		.index(index),
		.bus(bus.rom)
	);

	neuronMac #(
		.NUM_NEURONS(NUM_NEURONS)
	) neuronMac_i
	(
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.activations(activations),
		.bus(bus.mac)
	);

endmodule

`default_nettype wire

// File: source/inputCounter.sv
`timescale 1ns/100ps
`default_nettype none

module inputCounter
#(
	parameter int NUM_INPUTS = 30,
	localparam int INDEX_WIDTH = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
)
(
	input wire clk,
	input wire reset,
	input wire countClear,
	input wire countEnable,
	output logic [INDEX_WIDTH-1:0] index,
	output logic lastSample
);

	assign lastSample = (index == INDEX_WIDTH'(NUM_INPUTS - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
			index <= '0;
		else if (countClear)
			index <= '0;
		else if (countEnable)
		begin
			if (lastSample)
				index <= '0; // wrap at end of pass
			else
				index <= index + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		countEnable |-> (index <= INDEX_WIDTH'(NUM_INPUTS - 1)));

endmodule

`default_nettype wire

// File: source/layerControl.sv
`timescale 1ns/100ps
`default_nettype none

module layerControl
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire sampleValid,
	input wire lastSample,
	output logic countClear,
	output logic countEnable,
	output logic busy,
	output logic done,
	macBus.control bus
);

	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		FINISH
	} stateType;

	stateType state;
	stateType nextState;
	logic startPass;
	logic acceptSample;

	assign startPass = (state == IDLE) && start; // start while busy is dropped
	assign acceptSample = (state == LOAD) && sampleValid;

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (start)
					nextState = LOAD;
			LOAD:
				if (acceptSample && lastSample)
					nextState = FINISH;
			FINISH:
				nextState = IDLE;
			default:
				nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			done <= 1'b0;
		end
		else
		begin
			state <= nextState;
			done <= (state == FINISH); // one cycle, after activate
		end
	end

	assign bus.clear = startPass;
	assign bus.accumulate = acceptSample;
	assign bus.activate = (state == FINISH);
	assign countClear = startPass;
	assign countEnable = acceptSample;
	assign busy = (state != IDLE);

	assert property (@(posedge clk) disable iff (reset) !(done && busy));

endmodule

`default_nettype wire

// File: source/macBus.sv
`timescale 1ns/100ps
`default_nettype none

interface macBus
#(
	parameter int NUM_NEURONS = 4
);

	logic clear; // load biases
	logic accumulate; // sample accepted this cycle
	logic activate; // register activations
	nnPkg::dataWord weights [NUM_NEURONS];
	nnPkg::dataWord biases [NUM_NEURONS];

	modport control
	(
		output clear,
		output accumulate,
		output activate
	);

	modport rom
	(
		output weights,
		output biases
	);

	modport mac
	(
		input clear,
		input accumulate,
		input activate,
		input weights,
		input biases
	);

endinterface

`default_nettype wire

// File: source/neuronMac.sv
`timescale 1ns/100ps
`default_nettype none

module neuronMac
#(
	parameter int NUM_NEURONS = 4
)
(
	input wire clk,
	input wire reset,
	input wire nnPkg::dataWord sample,
	output nnPkg::actWord activations [NUM_NEURONS],
	macBus.mac bus
);

	localparam int ACT_SHIFT = 5; // output takes sum bits 12..5

	nnPkg::dataWord sums [NUM_NEURONS];
	nnPkg::dataWord products [NUM_NEURONS];

	function automatic nnPkg::actWord activationOf(input nnPkg::dataWord sum);
		if (sum[nnPkg::DATA_WIDTH-1])
			return '0; // negative
		else if (sum > nnPkg::SAT_LIMIT)
			return '1; // saturate
		else
			return sum[ACT_SHIFT +: nnPkg::ACT_WIDTH];
	endfunction

	// low 24 bits of the product match the signed result
	always_comb
	begin
		for (int n = 0; n < NUM_NEURONS; n++)
			products[n] = sample * bus.weights[n];
	end

	always_ff @(posedge clk)
	begin
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			if (bus.clear)
				sums[n] <= bus.biases[n];
			else if (bus.accumulate)
				sums[n] <= sums[n] + products[n]; // wraps at 24 bits
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
				activations[n] <= '0;
		end
		else if (bus.activate)
		begin
			for (int n = 0; n < NUM_NEURONS; n++)
				activations[n] <= activationOf(sums[n]);
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		bus.activate |-> !bus.accumulate && !bus.clear);

endmodule

`default_nettype wire

// File: source/nnPkg.sv
`default_nettype none

package nnPkg;

	localparam int MAX_INPUTS = 30;
	localparam int MAX_NEURONS = 4;
	localparam int DATA_WIDTH = 24;
	localparam int ACT_WIDTH = 8;
	localparam int SAT_LIMIT = 8192;

	typedef logic [DATA_WIDTH-1:0] dataWord;
	typedef logic [ACT_WIDTH-1:0] actWord;

	// one row per neuron, one column per input index
	localparam logic signed [DATA_WIDTH-1:0] weightTable [MAX_NEURONS][MAX_INPUTS] = '{
		'{
			-14, 1, 0, -3, 0, 0, -4, 0, -4, 0,
			-5, 0, 0, -1, 5, -15, -7, -7, -4, -10,
			-10, 3, 1, -4, 5, 2, -13, -12, -3, -2
		},
		'{
			3, -2, 7, 0, 1, -5, 4, 2, -1, 6,
			0, -3, 8, 1, -7, 2, 5, -4, 0, 3,
			-6, 9, 1, -2, 4, 0, -8, 2, 6, -1
		},
		'{
			-1, 4, -6, 2, 11, 0, -3, 5, 7, -2,
			1, 3, -9, 0, 2, 6, -4, 1, 8, -5,
			2, 0, 3, 12, -7, 1, 4, -2, 0, 5
		},
		'{
			15, -16, 2, 9, -3, 4, 0, -11, 6, 1,
			10, -2, 3, 7, -8, 0, 5, 13, -6, 2,
			-1, 8, -12, 4, 3, -5, 9, 0, -4, 14
		}
	};

	localparam logic signed [DATA_WIDTH-1:0] biasTable [MAX_NEURONS] = '{
		-2,
		5,
		-3,
		12
	};

endpackage

`default_nettype wire

// File: source/weightRom.sv
`timescale 1ns/100ps
`default_nettype none

module weightRom
#(
	parameter int NUM_INPUTS = 30,
	parameter int NUM_NEURONS = 4,
	localparam int INDEX_WIDTH = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
)
(
	input wire [INDEX_WIDTH-1:0] index,
	macBus.rom bus
);

	if (NUM_INPUTS > nnPkg::MAX_INPUTS || NUM_NEURONS > nnPkg::MAX_NEURONS)
	begin : gBoundsCheck
		$error("weight table too small for %0d inputs and %0d neurons",
			NUM_INPUTS, NUM_NEURONS);
	end

	always_comb
	begin
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			if (index < NUM_INPUTS)
				bus.weights[n] = nnPkg::weightTable[n][index];
			else
				bus.weights[n] = '0; // unused codes of index
			bus.biases[n] = nnPkg::biasTable[n];
		end
	end

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen
#(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 8
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // released on a rising edge
	end

endmodule

`default_nettype wire

// File: testbench/layerTb.sv
`timescale 1ns/100ps
`default_nettype none

module layerTb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_INPUTS = 30;
	localparam int NUM_NEURONS = 4;
	localparam int WORDS_PER_TEST = 2 + NUM_INPUTS + NUM_NEURONS;
	localparam int MAX_TESTS = 32;
	localparam int PASS_OVERHEAD = 10; // start, done and idle noise
	localparam int TIMEOUT_MARGIN = 100;
	localparam int DONE_LATENCY = 2;
	localparam int DONE_WAIT_LIMIT = 16;
	localparam int NOISE_INDEX = 10; // sample that carries a stray start
	localparam string STIMULUS_FILE = "testbench/layer_stimulus.txt";

	logic clk;
	logic reset;
	logic start;
	logic sampleValid;
	logic busy;
	logic done;
	nnPkg::dataWord sample;
	nnPkg::actWord activations [NUM_NEURONS];
	nnPkg::dataWord vectors [MAX_TESTS * WORDS_PER_TEST];
	int testCount;
	logic loaded = 1'b0;

	clockGen #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(RESET_CYCLES)
	) clockGen_i
	(
		.clk(clk),
		.reset(reset)
	);

	denseLayer denseLayer_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.sample(sample),
		.sampleValid(sampleValid),
		.activations(activations),
		.busy(busy),
		.done(done)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
			abortRun($sformatf("[FAIL] time %0d ns: %s is %0h, expected %0h",
				$time, what, got, expected));
	endtask

	function automatic nnPkg::dataWord wordAt(input int test, input int offset);
		return vectors[test * WORDS_PER_TEST + offset];
	endfunction

	task automatic loadStimulus();
		for (int i = 0; i < MAX_TESTS * WORDS_PER_TEST; i++)
			vectors[i] = '0;
		$readmemh(STIMULUS_FILE, vectors);
		testCount = 0;
		while (testCount < MAX_TESTS && wordAt(testCount, 0) != '0)
			testCount++; // test number 0 ends the list
	endtask

	task automatic waitForReset();
		@(negedge clk);
		while (reset)
			@(negedge clk);
		checkValue("busy after reset", busy, 0);
		checkValue("done after reset", done, 0);
		for (int n = 0; n < NUM_NEURONS; n++)
			checkValue($sformatf("activation %0d after reset", n), activations[n], 0);
	endtask

	task automatic beginPass();
		@(posedge clk);
		start <= 1'b1;
		sampleValid <= 1'b0;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		checkValue("busy after start", busy, 1);
	endtask

	task automatic presentSample(input nnPkg::dataWord value, input int gap,
		input bit alsoStart);
		for (int g = 0; g < gap; g++)
		begin
			@(posedge clk);
			sampleValid <= 1'b0;
			start <= 1'b0;
			sample <= ~value; // junk while not valid
		end
		@(posedge clk);
		sample <= value;
		sampleValid <= 1'b1;
		start <= alsoStart;
		@(negedge clk);
		checkValue("busy during pass", busy, 1);
		checkValue("done during pass", done, 0);
	endtask

	// counts cycles from the one holding the last sample
	task automatic checkDone(input int testNum);
		int latency;
		latency = 1;
		@(negedge clk);
		while (!done)
		begin
			checkValue("busy before done", busy, 1);
			if (latency >= DONE_WAIT_LIMIT)
				abortRun($sformatf("test %0d: done never came", testNum));
			latency++;
			@(negedge clk);
		end
		checkValue("cycles from last sample to done", latency, DONE_LATENCY);
		checkValue("busy with done", busy, 0);
	endtask

	task automatic runTest(input int t);
		int testNum;
		int gap;
		bit noisy;
		testNum = wordAt(t, 0);
		gap = wordAt(t, 1);
		noisy = (testNum % 2 == 0);
		if (noisy)
		begin
			@(posedge clk);
			sample <= 24'h5A5A5A; // strobe while idle
			sampleValid <= 1'b1;
		end
		beginPass();
		for (int i = 0; i < NUM_INPUTS; i++)
			presentSample(wordAt(t, 2 + i), gap, noisy && i == NOISE_INDEX);
		@(posedge clk);
		sampleValid <= 1'b0;
		start <= 1'b0;
		checkDone(testNum);
		for (int n = 0; n < NUM_NEURONS; n++)
			checkValue($sformatf("test %0d neuron %0d", testNum, n), activations[n],
				wordAt(t, 2 + NUM_INPUTS + n));
		@(negedge clk);
		checkValue("done one cycle later", done, 0);
		checkValue("busy after pass", busy, 0);
	endtask

	initial
	begin : watchdog
		int budget;
		wait (loaded);
		budget = RESET_CYCLES + TIMEOUT_MARGIN;
		for (int t = 0; t < testCount; t++)
			budget += NUM_INPUTS * (int'(wordAt(t, 1)) + 1) + PASS_OVERHEAD;
		#(budget * CLK_PERIOD);
		abortRun($sformatf("timeout: run still going after %0d clock cycles", budget));
	end

	initial
	begin
		start = 1'b0;
		sample = '0;
		sampleValid = 1'b0;
		loadStimulus();
		if (testCount == 0)
			abortRun("no tests found in the stimulus file");
		loaded = 1'b1;
		waitForReset();
		for (int t = 0; t < testCount; t++)
			runTest(t);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/layer_stimulus.txt
// per test, hex: test number, gap cycles; then 30 samples; then 4 expected activations
// a test number of 0 or the end of the file ends the list
01 00 // all samples zero, biases alone
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
00 00 00 00
02 00 // small positive samples
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064
00 4E 76 93
03 00 // large samples, saturation and negative mix
3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
00 FF FF FF
04 00 // large negative samples
FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18
FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18
FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18 FFFC18
FF 00 00 00
05 03 // same data as test 2 with gaps
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064
00 4E 76 93
06 01 // two nonzero inputs at index 4 and 23
0 0 0 0 12C 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 FA 0 0 0 0 0 0
00 00 C4 03
07 03 // same data as test 3 with gaps
3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
00 FF FF FF
08 02 // products wrap at 24 bits
100000 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
FF FF 00 00
